//--- rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int PC_W       = 30;    // word address, byte bits dropped

    localparam logic [PC_W-1:0] RESET_PC = '0;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_WORD = 3'b010;    // lw / sw

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;    // addi x0, x0, 0

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B    // lui
    } alu_op_t;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [REG_ADDR_W-1:0]  rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [REG_ADDR_W-1:0]  rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [REG_ADDR_W-1:0]  rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        imm;
        alu_op_t                alu_op;
        logic                   use_imm;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
    } dec_exec_t;

    typedef struct packed {
        logic [XLEN-1:0]        result;
        logic [XLEN-1:0]        store_data;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
    } exec_mem_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        data;
        logic                   reg_write;
    } wb_t;

    typedef struct packed {
        logic [XLEN-1:0]        addr;
        logic [XLEN-1:0]        wdata;
        logic                   we;
    } dmem_req_t;

endpackage

//--- rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch
(
    input   logic                       i_clk,
    input   logic                       i_reset,
    input   logic                       i_stall,
    output  logic [rv_pkg::PC_W-1:0]    o_pc
);

    import rv_pkg::*;

    logic [PC_W-1:0]    r_pc;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            r_pc <= RESET_PC;
        else if (!i_stall)
            r_pc <= r_pc + 1'b1;    // one word per cycle
    end

    assign o_pc = r_pc;

    // a held pc keeps imem re-reading the next word while decode holds its own
    a_pc_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |=> $stable(r_pc));

endmodule

//--- rv_decode.sv
`timescale 1ns/10ps

module rv_decode
(
    input   logic                           i_clk,
    input   logic                           i_reset,
    input   logic                           i_stall,
    input   rv_pkg::instr_t                 i_instr,
    input   logic [rv_pkg::PC_W-1:0]        i_pc,
    output  logic [rv_pkg::REG_ADDR_W-1:0]  o_rs1,
    output  logic [rv_pkg::REG_ADDR_W-1:0]  o_rs2,
    output  rv_pkg::dec_exec_t              o_ctrl
);

    import rv_pkg::*;

    logic               r_valid;
    logic               r_hold;     // word held since the last stall
    instr_t             r_instr;
    logic [PC_W-1:0]    r_pc;       // address of the word in decode
    instr_t             w_instr;
    dec_exec_t          w_ctrl;

    function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_valid <= 1'b0;
            r_hold  <= 1'b0;
        end
        else
        begin
            r_hold <= i_stall;
            if (!i_stall)
                r_valid <= 1'b1;
        end
    end

    // imem moves on to the next word during a stall
    always_ff @(posedge i_clk)
    begin
        if (!r_hold)
            r_instr <= i_instr;
        if (!i_stall)
            r_pc <= i_pc;
    end

    assign w_instr = r_hold ? r_instr : i_instr;

    always_comb
    begin
        w_ctrl = '0;    // no-op unless decoded below
        case (w_instr.r.opcode)
            OPC_OP:
            begin
                w_ctrl.rs1       = w_instr.r.rs1;
                w_ctrl.rs2       = w_instr.r.rs2;
                w_ctrl.rd        = w_instr.r.rd;
                w_ctrl.alu_op    = alu_sel(w_instr.r.funct3, w_instr.r.funct7[5]);
                w_ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                w_ctrl.rs1       = w_instr.i.rs1;
                w_ctrl.rd        = w_instr.i.rd;
                w_ctrl.imm       = {{20{w_instr.i.imm[11]}}, w_instr.i.imm};
                w_ctrl.use_imm   = 1'b1;
                // only srai uses imm bit 10 as the alternate bit
                w_ctrl.alu_op    = alu_sel(w_instr.i.funct3,
                                           w_instr.i.funct3 == 3'b101 && w_instr.i.imm[10]);
                w_ctrl.reg_write = 1'b1;
            end
            OPC_LUI:
            begin
                w_ctrl.rd        = w_instr.u.rd;
                w_ctrl.imm       = {w_instr.u.imm, 12'b0};
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.alu_op    = ALU_PASS_B;
                w_ctrl.reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                if (w_instr.i.funct3 == F3_WORD)
                begin
                    w_ctrl.rs1       = w_instr.i.rs1;
                    w_ctrl.rd        = w_instr.i.rd;
                    w_ctrl.imm       = {{20{w_instr.i.imm[11]}}, w_instr.i.imm};
                    w_ctrl.use_imm   = 1'b1;
                    w_ctrl.reg_write = 1'b1;
                    w_ctrl.mem_read  = 1'b1;
                end
            end
            OPC_STORE:
            begin
                if (w_instr.s.funct3 == F3_WORD)
                begin
                    w_ctrl.rs1       = w_instr.s.rs1;
                    w_ctrl.rs2       = w_instr.s.rs2;
                    w_ctrl.imm       = {{20{w_instr.s.imm_hi[6]}}, w_instr.s.imm_hi,
                                        w_instr.s.imm_lo};
                    w_ctrl.use_imm   = 1'b1;
                    w_ctrl.mem_write = 1'b1;
                end
            end
            default: ;
        endcase
        if (!r_valid)
            w_ctrl = '0;
    end

    assign o_ctrl = w_ctrl;
    assign o_rs1  = w_ctrl.rs1;    // zero when the field is unused
    assign o_rs2  = w_ctrl.rs2;

    // fetch stays exactly one word ahead of decode, stalls included
    a_pc_lead: assert property (@(posedge i_clk) disable iff (i_reset)
        r_valid |-> i_pc == r_pc + 1'b1);

endmodule

//--- rv_regs.sv
`timescale 1ns/10ps

module rv_regs
(
    input   logic                           i_clk,
    input   logic [rv_pkg::REG_ADDR_W-1:0]  i_rs1,
    input   logic [rv_pkg::REG_ADDR_W-1:0]  i_rs2,
    input   rv_pkg::wb_t                    i_wb,
    output  logic [rv_pkg::XLEN-1:0]        o_data1,
    output  logic [rv_pkg::XLEN-1:0]        o_data2
);

    import rv_pkg::*;

    logic [XLEN-1:0]    r_regs [0:31];    // entry 0 never written

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (i_wb.reg_write && i_wb.rd == idx)
            return i_wb.data;    // write first
        return r_regs[idx];
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_wb.reg_write && i_wb.rd != '0)
            r_regs[i_wb.rd] <= i_wb.data;
    end

    always_comb
    begin
        o_data1 = read_port(i_rs1);
        o_data2 = read_port(i_rs2);
    end

    a_x0_zero: assert property (@(posedge i_clk)
        (i_rs1 == '0 |-> o_data1 == '0) and (i_rs2 == '0 |-> o_data2 == '0));

endmodule

//--- rv_exec.sv
`timescale 1ns/10ps

module rv_exec
(
    input   logic                       i_clk,
    input   logic                       i_reset,
    input   logic                       i_stall,
    input   logic                       i_bubble,
    input   rv_pkg::dec_exec_t          i_ctrl,
    input   logic [rv_pkg::XLEN-1:0]    i_rs1_val,
    input   logic [rv_pkg::XLEN-1:0]    i_rs2_val,
    input   rv_pkg::fwd_sel_t           i_fwd_a,
    input   rv_pkg::fwd_sel_t           i_fwd_b,
    input   logic [rv_pkg::XLEN-1:0]    i_mem_fwd,
    input   rv_pkg::wb_t                i_wb,
    output  rv_pkg::dec_exec_t          o_ctrl,
    output  rv_pkg::exec_mem_t          o_out
);

    import rv_pkg::*;

    dec_exec_t          r_ctrl;
    logic [XLEN-1:0]    r_rs1_val;
    logic [XLEN-1:0]    r_rs2_val;
    logic [XLEN-1:0]    w_op_a;
    logic [XLEN-1:0]    w_rs2_fwd;
    logic [XLEN-1:0]    w_op_b;
    logic [XLEN-1:0]    w_result;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                 input logic [XLEN-1:0] held,
                                                 input logic [XLEN-1:0] mem_val,
                                                 input logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return held;
        endcase
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            r_ctrl <= '0;
        else if (!i_stall)
            r_ctrl <= i_bubble ? '0 : i_ctrl;    // bubble on load-use
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            r_rs1_val <= i_rs1_val;
            r_rs2_val <= i_rs2_val;
        end
    end

    always_comb
    begin
        w_op_a    = fwd_mux(i_fwd_a, r_rs1_val, i_mem_fwd, i_wb.data);
        w_rs2_fwd = fwd_mux(i_fwd_b, r_rs2_val, i_mem_fwd, i_wb.data);
        w_op_b    = r_ctrl.use_imm ? r_ctrl.imm : w_rs2_fwd;
    end

    always_comb
    begin
        case (r_ctrl.alu_op)
            ALU_ADD:  w_result = w_op_a + w_op_b;
            ALU_SUB:  w_result = w_op_a - w_op_b;
            ALU_SLL:  w_result = w_op_a << w_op_b[4:0];
            ALU_SLT:  w_result = {31'b0, $signed(w_op_a) < $signed(w_op_b)};
            ALU_SLTU: w_result = {31'b0, w_op_a < w_op_b};
            ALU_XOR:  w_result = w_op_a ^ w_op_b;
            ALU_SRL:  w_result = w_op_a >> w_op_b[4:0];
            ALU_SRA:  w_result = $signed(w_op_a) >>> w_op_b[4:0];
            ALU_OR:   w_result = w_op_a | w_op_b;
            ALU_AND:  w_result = w_op_a & w_op_b;
            default:  w_result = w_op_b;    // pass b
        endcase
    end

    assign o_ctrl = r_ctrl;

    always_comb
    begin
        o_out.result     = w_result;
        o_out.store_data = w_rs2_fwd;
        o_out.rd         = r_ctrl.rd;
        o_out.reg_write  = r_ctrl.reg_write;
        o_out.mem_read   = r_ctrl.mem_read;
        o_out.mem_write  = r_ctrl.mem_write;
    end

endmodule

//--- rv_mem_wb.sv
`timescale 1ns/10ps

module rv_mem_wb
(
    input   logic                           i_clk,
    input   logic                           i_reset,
    input   logic                           i_stall,
    input   rv_pkg::exec_mem_t              i_in,
    output  rv_pkg::dmem_req_t              o_dmem_req,
    output  logic                           o_dmem_valid,
    input   logic                           i_dmem_ack,
    input   logic [rv_pkg::XLEN-1:0]        i_dmem_rdata,
    output  logic [rv_pkg::XLEN-1:0]        o_mem_fwd,
    output  logic [rv_pkg::REG_ADDR_W-1:0]  o_mem_rd,
    output  logic                           o_mem_write_en,
    output  rv_pkg::wb_t                    o_wb
);

    import rv_pkg::*;

    exec_mem_t  r_mem;
    wb_t        r_wb;

    // both registers hold while the data access waits
    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            r_mem        <= i_in;
            r_wb.rd      <= r_mem.rd;
            r_wb.data    <= r_mem.mem_read ? i_dmem_rdata : r_mem.result;
            r_wb.reg_write <= r_mem.reg_write;
        end
        if (i_reset)
        begin
            r_mem.reg_write <= 1'b0;
            r_mem.mem_read  <= 1'b0;
            r_mem.mem_write <= 1'b0;
            r_wb.reg_write  <= 1'b0;
        end
    end

    always_comb
    begin
        o_dmem_req.addr  = r_mem.result;
        o_dmem_req.wdata = r_mem.store_data;
        o_dmem_req.we    = r_mem.mem_write;
    end

    assign o_dmem_valid   = r_mem.mem_read | r_mem.mem_write;
    assign o_mem_fwd      = r_mem.result;
    assign o_mem_rd       = r_mem.rd;
    assign o_mem_write_en = r_mem.reg_write;
    assign o_wb           = r_wb;

    a_word_addr: assert property (@(posedge i_clk) disable iff (i_reset)
        o_dmem_valid |-> o_dmem_req.addr[1:0] == 2'b00);

    // the hazard unit must hold this stage until the ack
    a_req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_dmem_valid && !i_dmem_ack |=> o_dmem_valid && $stable(o_dmem_req));

endmodule

//--- rv_hazard.sv
`timescale 1ns/10ps

module rv_hazard
(
    input   logic [rv_pkg::REG_ADDR_W-1:0]  i_rs1,
    input   logic [rv_pkg::REG_ADDR_W-1:0]  i_rs2,
    input   rv_pkg::dec_exec_t              i_exec,
    input   logic [rv_pkg::REG_ADDR_W-1:0]  i_mem_rd,
    input   logic                           i_mem_write_en,
    input   logic [rv_pkg::REG_ADDR_W-1:0]  i_wb_rd,
    input   logic                           i_wb_write_en,
    input   logic                           i_dmem_valid,
    input   logic                           i_dmem_ack,
    output  rv_pkg::fwd_sel_t               o_fwd_a,
    output  rv_pkg::fwd_sel_t               o_fwd_b,
    output  logic                           o_load_stall,
    output  logic                           o_bus_stall
);

    import rv_pkg::*;

    function automatic fwd_sel_t fwd_src(input logic [REG_ADDR_W-1:0] rs);
        if (rs == '0)
            return FWD_REG;
        if (i_mem_write_en && i_mem_rd == rs)
            return FWD_MEM;    // youngest result wins
        if (i_wb_write_en && i_wb_rd == rs)
            return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb
    begin
        o_fwd_a = fwd_src(i_exec.rs1);
        o_fwd_b = fwd_src(i_exec.rs2);
    end

    // unused rs fields come from decode as zero
    assign o_load_stall = i_exec.mem_read && i_exec.rd != '0 &&
                          (i_exec.rd == i_rs1 || i_exec.rd == i_rs2);

    assign o_bus_stall = i_dmem_valid & ~i_dmem_ack;

endmodule

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core
(
    input   logic                       i_clk,
    input   logic                       i_reset,
    output  logic [rv_pkg::PC_W-1:0]    o_imem_addr,
    input   logic [rv_pkg::XLEN-1:0]    i_imem_data,
    output  rv_pkg::dmem_req_t          o_dmem_req,
    output  logic                       o_dmem_valid,
    input   logic                       i_dmem_ack,
    input   logic [rv_pkg::XLEN-1:0]    i_dmem_rdata
);

    import rv_pkg::*;

    logic [PC_W-1:0]        w_fetch_pc;
    logic [REG_ADDR_W-1:0]  w_dec_rs1;
    logic [REG_ADDR_W-1:0]  w_dec_rs2;
    dec_exec_t              w_dec_ctrl;
    logic [XLEN-1:0]        w_reg_data1;
    logic [XLEN-1:0]        w_reg_data2;
    dec_exec_t              w_exec_ctrl;
    exec_mem_t              w_exec_out;
    logic [XLEN-1:0]        w_mem_fwd;
    logic [REG_ADDR_W-1:0]  w_mem_rd;
    logic                   w_mem_write_en;
    wb_t                    w_wb;
    fwd_sel_t               w_fwd_a;
    fwd_sel_t               w_fwd_b;
    logic                   w_load_stall;
    logic                   w_bus_stall;
    logic                   w_front_stall;

    assign w_front_stall = w_load_stall | w_bus_stall;    // fetch and decode
    assign o_imem_addr   = w_fetch_pc;

    rv_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (w_front_stall),
        .o_pc           (w_fetch_pc)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (w_front_stall),
        .i_instr        (i_imem_data),
        .i_pc           (w_fetch_pc),
        .o_rs1          (w_dec_rs1),
        .o_rs2          (w_dec_rs2),
        .o_ctrl         (w_dec_ctrl)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_rs1          (w_dec_rs1),
        .i_rs2          (w_dec_rs2),
        .i_wb           (w_wb),
        .o_data1        (w_reg_data1),
        .o_data2        (w_reg_data2)
    );

    rv_exec u_exec
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (w_bus_stall),
        .i_bubble       (w_load_stall),
        .i_ctrl         (w_dec_ctrl),
        .i_rs1_val      (w_reg_data1),
        .i_rs2_val      (w_reg_data2),
        .i_fwd_a        (w_fwd_a),
        .i_fwd_b        (w_fwd_b),
        .i_mem_fwd      (w_mem_fwd),
        .i_wb           (w_wb),
        .o_ctrl         (w_exec_ctrl),
        .o_out          (w_exec_out)
    );

    rv_mem_wb u_mem_wb
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (w_bus_stall),
        .i_in           (w_exec_out),
        .o_dmem_req     (o_dmem_req),
        .o_dmem_valid   (o_dmem_valid),
        .i_dmem_ack     (i_dmem_ack),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_mem_fwd      (w_mem_fwd),
        .o_mem_rd       (w_mem_rd),
        .o_mem_write_en (w_mem_write_en),
        .o_wb           (w_wb)
    );

    rv_hazard u_hazard
    (
        .i_rs1          (w_dec_rs1),
        .i_rs2          (w_dec_rs2),
        .i_exec         (w_exec_ctrl),
        .i_mem_rd       (w_mem_rd),
        .i_mem_write_en (w_mem_write_en),
        .i_wb_rd        (w_wb.rd),
        .i_wb_write_en  (w_wb.reg_write),
        .i_dmem_valid   (o_dmem_valid),
        .i_dmem_ack     (i_dmem_ack),
        .o_fwd_a        (w_fwd_a),
        .o_fwd_b        (w_fwd_b),
        .o_load_stall   (w_load_stall),
        .o_bus_stall    (w_bus_stall)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock
(
    output logic o_clk
);

    localparam real HALF_PERIOD = 2.0;    // 4 ns period

    initial
    begin
        o_clk = 1'b0;
        forever
            #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    import rv_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DATA_WORDS   = 64;
    localparam int MODE_PLAIN   = 0;
    localparam int MODE_DEP     = 1;    // sources from the last three results
    localparam int MODE_LU      = 2;    // every load is used by the next instruction
    localparam int MODE_X0      = 3;

    logic               clk;
    logic               reset;
    logic [PC_W-1:0]    imem_addr;
    logic [XLEN-1:0]    imem_data;
    dmem_req_t          dmem_req;
    logic               dmem_valid;
    logic               dmem_ack;
    logic [XLEN-1:0]    dmem_rdata;

    logic [PC_W-1:0]    imem_addr_q = '0;
    logic [31:0]        prog[$];
    dmem_req_t          exp_q[$];       // data accesses the model expects, in order
    logic [XLEN-1:0]    model_regs[32];
    logic [XLEN-1:0]    model_mem[DATA_WORDS];
    logic [XLEN-1:0]    env_mem[DATA_WORDS];
    logic [4:0]         recent[3];
    int                 wait_left = 0;
    int                 errors    = 0;
    int                 checks    = 0;
    int                 accesses  = 0;
    int                 tests     = 0;
    bit                 timed_out = 1'b0;

    tb_clock u_clock (.o_clk(clk));

    rv_core i_rv_core
    (
        .i_clk          (clk),
        .i_reset        (reset),
        .o_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .o_dmem_req     (dmem_req),
        .o_dmem_valid   (dmem_valid),
        .i_dmem_ack     (dmem_ack),
        .i_dmem_rdata   (dmem_rdata)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [PC_W-1:0] addr);
        if (addr < PC_W'(prog.size()))
            return prog[addr];
        return NOP_INSTR;    // past the end of the program
    endfunction

    // rv32i arithmetic as the isa defines it
    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(input logic [31:0] w);
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        logic [2:0]         f3;
        logic [XLEN-1:0]    imm_i;
        logic [XLEN-1:0]    imm_s;
        logic [XLEN-1:0]    res;
        logic               wr;
        dmem_req_t          req;
        rd    = w[11:7];
        rs1   = w[19:15];
        rs2   = w[24:20];
        f3    = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        res   = '0;
        wr    = 1'b1;
        case (w[6:0])
            OPC_OP:     res = alu_model(f3, w[30], model_regs[rs1], model_regs[rs2]);
            OPC_OP_IMM: res = alu_model(f3, f3 == 3'd5 && w[30], model_regs[rs1], imm_i);
            OPC_LUI:    res = {w[31:12], 12'b0};
            OPC_LOAD:
            begin
                req.addr  = model_regs[rs1] + imm_i;
                req.wdata = '0;
                req.we    = 1'b0;
                exp_q.push_back(req);
                res = model_mem[req.addr[7:2]];
            end
            OPC_STORE:
            begin
                req.addr  = model_regs[rs1] + imm_s;
                req.wdata = model_regs[rs2];
                req.we    = 1'b1;
                exp_q.push_back(req);
                model_mem[req.addr[7:2]] = req.wdata;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0)
            model_regs[rd] = res;
    endtask

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
        model_step(w);
    endtask

    task automatic build_program(input int n, input int w_rr, input int w_imm, input int w_lui,
                                 input int w_ld, input int w_st, input int mode);
        int             pick;
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic [11:0]    imm;
        logic [11:0]    off;
        prog.delete();
        exp_q.delete();
        for (int k = 0; k < 32; k++)
            model_regs[k] = '0;
        for (int k = 0; k < DATA_WORDS; k++)
        begin
            model_mem[k] = $urandom;
            env_mem[k]   = model_mem[k];
        end
        // register file has no reset, so every register gets a value first
        for (int k = 1; k < 32; k++)
        begin
            emit({20'($urandom), 5'(k), OPC_LUI});
            emit(enc_i(12'($urandom), 5'(k), 3'd0, 5'(k), OPC_OP_IMM));
        end
        recent = '{5'd29, 5'd30, 5'd31};
        for (int k = 0; k < n; k++)
        begin
            pick = $urandom_range(w_rr + w_imm + w_lui + w_ld + w_st - 1);
            rd   = 5'($urandom_range(31, 1));
            rs1  = (mode == MODE_DEP) ? recent[$urandom_range(2)] : 5'($urandom);
            rs2  = (mode == MODE_DEP) ? recent[$urandom_range(2)] : 5'($urandom);
            f3   = 3'($urandom);
            off  = 12'($urandom_range(DATA_WORDS - 1) * 4);
            if (mode == MODE_X0 && $urandom_range(3) == 0)
                rd = 5'd0;
            if (mode == MODE_X0 && $urandom_range(3) == 0)
                rs2 = 5'd0;
            if (pick < w_rr)
            begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
                emit(enc_r(f7, rs2, rs1, f3, rd));
            end
            else if (pick < w_rr + w_imm)
            begin
                imm = 12'($urandom);
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm[11:5] = (f3 == 3'd5 && imm[11]) ? 7'h20 : 7'h00;    // shamt forms
                emit(enc_i(imm, rs1, f3, rd, OPC_OP_IMM));
            end
            else if (pick < w_rr + w_imm + w_lui)
                emit({20'($urandom), rd, OPC_LUI});
            else if (pick < w_rr + w_imm + w_lui + w_ld)
            begin
                emit(enc_i(off, 5'd0, F3_WORD, rd, OPC_LOAD));
                if (mode == MODE_LU)
                    emit(enc_r(7'h00, rs2, rd, 3'd0, 5'($urandom_range(31, 1))));
            end
            else
                emit(enc_s(off, rs2, 5'd0));
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = rd;
        end
        for (int k = 1; k < 32; k++)
            emit(enc_s(12'(k * 4), 5'(k), 5'd0));    // register dump
    endtask

    task automatic check_req(input dmem_req_t exp, input dmem_req_t got);
        checks++;
        if (got.addr !== exp.addr)
        begin
            $display("Error at %0t: o_dmem_req.addr expected %h got %h", $time, exp.addr,
                     got.addr);
            errors++;
        end
        if (got.we !== exp.we)
        begin
            $display("Error at %0t: o_dmem_req.we expected %b got %b", $time, exp.we, got.we);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] got);
        checks++;
        if (got !== exp)
        begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [PC_W-1:0] exp, input logic [PC_W-1:0] got);
        checks++;
        if (got !== exp)
        begin
            $display("Error at %0t: o_imem_addr expected %h got %h", $time, exp, got);
            errors++;
        end
    endtask

    task automatic serve_access();
        dmem_req_t exp;
        accesses++;
        if (exp_q.size() == 0)
        begin
            $display("unexpected data access to %h at %0t, the model issues no more",
                     dmem_req.addr, $time);
            errors++;
        end
        else
        begin
            exp = exp_q.pop_front();
            check_req(exp, dmem_req);
            if (exp.we)
                check_word("o_dmem_req.wdata", exp.wdata, dmem_req.wdata);
        end
        if (dmem_req.we)
            env_mem[dmem_req.addr[7:2]] = dmem_req.wdata;
        else
            dmem_rdata = env_mem[dmem_req.addr[7:2]];
        dmem_ack = 1'b1;
    endtask

    always @(posedge clk)
        imem_addr_q <= imem_addr;

    always @(negedge clk)
        imem_data = fetch_word(imem_addr_q);    // sync read, one cycle after the address

    always @(negedge clk)
    begin
        if (reset)
        begin
            dmem_ack  = 1'b0;
            wait_left = $urandom_range(3);
        end
        else
        begin
            if (dmem_ack)
            begin
                dmem_ack  = 1'b0;    // closed at the last rising edge
                wait_left = $urandom_range(3);
            end
            if (dmem_valid)
            begin
                if (wait_left != 0)
                    wait_left--;
                else
                    serve_access();
            end
        end
    end

    task automatic run_test(input string name, input int n, input int w_rr, input int w_imm,
                            input int w_lui, input int w_ld, input int w_st, input int mode);
        int err_start;
        int acc_start;
        int limit;
        int cycles;
        if (timed_out)
            return;
        err_start = errors;
        acc_start = accesses;
        @(negedge clk);
        reset <= 1'b1;
        build_program(n, w_rr, w_imm, w_lui, w_ld, w_st, mode);
        repeat (RESET_CYCLES) @(negedge clk);
        check_pc('0, imem_addr);    // first fetch is word 0
        reset <= 1'b0;
        // up to four cycles per access wait, five stages deep
        limit  = 4 * prog.size() * 5 + RESET_CYCLES;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            $display("test %s stopped after %0d cycles with %0d data accesses still missing",
                     name, cycles, exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
        else
            repeat (8) @(posedge clk);    // catch stray accesses
        tests++;
        $display("test %-9s done: %0d accesses, %0d errors", name, accesses - acc_start,
                 errors - err_start);
    endtask

    initial
    begin
        void'($urandom(74));
        reset      = 1'b1;
        imem_data  = NOP_INSTR;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        run_test("alu_rr", 60, 10, 0, 0, 0, 0, MODE_PLAIN);
        run_test("alu_imm", 60, 0, 8, 2, 0, 0, MODE_PLAIN);
        run_test("forward", 80, 5, 4, 1, 0, 0, MODE_DEP);
        run_test("load_use", 60, 2, 2, 0, 4, 2, MODE_LU);
        run_test("bus_order", 100, 3, 3, 1, 3, 3, MODE_DEP);
        run_test("x0_write", 60, 3, 3, 1, 1, 2, MODE_X0);
        $display("tests %0d, accesses %0d, checks %0d, errors %0d", tests, accesses, checks,
                 errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- list.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_exec.sv
rv_mem_wb.sv
rv_hazard.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
    -f list.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
